// File: frame_capture_settings.svh
`ifndef FRAME_CAPTURE_SETTINGS_SVH
`define FRAME_CAPTURE_SETTINGS_SVH

////////////////////////////////////////
// Frame geometry
////////////////////////////////////////

// Bank count, a power of two from 1 to 8
`define FC_NUM_BANKS 4
// 64 for simulation, 307200 for a full 640x480 frame
`define FC_FRAME_PIXELS 64
`define FC_BANK_DEPTH (`FC_FRAME_PIXELS / `FC_NUM_BANKS)
`define FC_BANK_ADDR_BITS $clog2(`FC_BANK_DEPTH)
// One extra code so the count can hold a full frame
`define FC_PIXEL_ADDR_BITS $clog2(`FC_FRAME_PIXELS + 1)
// Green/luma byte only
`define FC_PIXEL_BITS 8

////////////////////////////////////////
// APB register map
////////////////////////////////////////

`define FC_REG_CTRL 12'h000
`define FC_REG_STATUS 12'h004
`define FC_PIXEL_BASE 12'h400

`endif

// File: frame_capture_pkg.sv
`include "frame_capture_settings.svh"

package frame_capture_pkg;

    ////////////////////////////////////////
    // Camera side
    ////////////////////////////////////////

    // One camera cycle, pulses as the sensor delivers them
    typedef struct packed {
        logic [31:0] data;
        logic        pixel_done;
        logic        frame_done;
    } cam_word_t;

    // Distributor to one bank
    typedef struct packed {
        logic                            we;
        logic [`FC_BANK_ADDR_BITS-1:0] addr;
        logic [`FC_PIXEL_BITS-1:0]     data;
    } bank_write_t;

    // Two-step save, then hold until re-armed
    typedef enum logic [1:0] {
        WAIT_PIXEL,
        SAVE_PIXEL,
        FROZEN
    } bank_state_e;

    ////////////////////////////////////////
    // Host side
    ////////////////////////////////////////

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS_WAIT,
        ACCESS_DONE
    } apb_phase_e;

endpackage

// File: pixel_distributor.sv
`timescale 1ns/1ps
`include "frame_capture_settings.svh"

module pixel_distributor (
    input  logic                                 clk,
    input  logic                                 reset,
    input  frame_capture_pkg::cam_word_t         cam,
    input  logic                                 rearm,
    output frame_capture_pkg::bank_write_t       bank_wr [`FC_NUM_BANKS],
    output logic                                 frozen,
    output logic                                 frame_valid,
    output logic                                 overflow,
    output logic                                 armed,
    output logic [`FC_PIXEL_ADDR_BITS-1:0]       pixel_count
);

    localparam int NB = `FC_NUM_BANKS;
    localparam int FRAME_PIXELS = `FC_FRAME_PIXELS;
    localparam int ABITS = `FC_BANK_ADDR_BITS;

    logic                      new_pixel;
    logic                      frame_full;
    logic                      accept;
    logic [NB-1:0]             wr_en_q;
    logic [ABITS-1:0]          wr_addr_q;
    logic [`FC_PIXEL_BITS-1:0] wr_data_q;

    // frame_done wins over a pixel in the same cycle
    assign new_pixel = cam.pixel_done && !cam.frame_done && !frozen;
    assign frame_full = int'(pixel_count) >= FRAME_PIXELS;
    assign accept = new_pixel && !frame_full;

    ////////////////////////////////////////
    // Frame state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || rearm) begin
            frozen      <= 1'b0;
            overflow    <= 1'b0;
            pixel_count <= '0;
        end else begin
            if (cam.frame_done) begin
                frozen <= 1'b1;
            end
            // Extra pixels are dropped and never wrapped
            if (new_pixel && frame_full) begin
                overflow <= 1'b1;
            end
            if (accept) begin
                pixel_count <= pixel_count + 1'b1;
            end
        end
    end

    // A frozen frame is the valid one
    assign frame_valid = frozen;
    assign armed = !frozen;

    ////////////////////////////////////////
    // Round-robin steering
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || rearm) begin
            wr_en_q <= '0;
        end else begin
            for (int i = 0; i < NB; i++) begin
                wr_en_q[i] <= accept && (int'(pixel_count) % NB == i);
            end
        end
    end

    // Payload shared by all banks and only one enable is live
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr_q <= ABITS'(int'(pixel_count) / NB);
            // Keep green/luma
            wr_data_q <= cam.data[23:16];
        end
    end

    for (genvar i = 0; i < NB; i++) begin : g_wr
        assign bank_wr[i] = '{we: wr_en_q[i], addr: wr_addr_q, data: wr_data_q};
    end

    // No bank write once the frame is frozen
    assert property (@(posedge clk) disable iff (reset) (|wr_en_q) |-> !frozen);

endmodule

// File: frame_bank_writer.sv
`timescale 1ns/1ps
`include "frame_capture_settings.svh"

module frame_bank_writer (
    input  logic                               clk,
    input  logic                               reset,
    input  frame_capture_pkg::bank_write_t     wr,
    input  logic                               frozen,
    input  logic [`FC_BANK_ADDR_BITS-1:0]      rd_addr,
    output logic [`FC_PIXEL_BITS-1:0]          rd_data
);

    localparam int ABITS = `FC_BANK_ADDR_BITS;
    localparam int PBITS = `FC_PIXEL_BITS;
    localparam int DEPTH = `FC_BANK_DEPTH;

    frame_capture_pkg::bank_state_e state;

    logic [ABITS-1:0] addr_q;
    logic [PBITS-1:0] pixel_q;
    logic             ram_we;
    logic [PBITS-1:0] mem [DEPTH];

    ////////////////////////////////////////
    // Capture FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= frame_capture_pkg::WAIT_PIXEL;
        end else begin
            case (state)
                frame_capture_pkg::WAIT_PIXEL: begin
                    // A pending pixel is saved before freezing
                    if (wr.we) begin
                        state <= frame_capture_pkg::SAVE_PIXEL;
                    end else if (frozen) begin
                        state <= frame_capture_pkg::FROZEN;
                    end
                end
                frame_capture_pkg::SAVE_PIXEL: begin
                    state <= frozen ? frame_capture_pkg::FROZEN
                                    : frame_capture_pkg::WAIT_PIXEL;
                end
                frame_capture_pkg::FROZEN: begin
                    // Held until the host re-arms
                    if (!frozen) begin
                        state <= frame_capture_pkg::WAIT_PIXEL;
                    end
                end
                default: begin
                    state <= frame_capture_pkg::WAIT_PIXEL;
                end
            endcase
        end
    end

    // Latch pixel and slot while waiting
    always_ff @(posedge clk) begin
        if (state == frame_capture_pkg::WAIT_PIXEL && wr.we) begin
            addr_q  <= wr.addr;
            pixel_q <= wr.data;
        end
    end

    assign ram_we = (state == frame_capture_pkg::SAVE_PIXEL);

    ////////////////////////////////////////
    // Bank RAM
    ////////////////////////////////////////

    // Registered read port for the host side
    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[addr_q] <= pixel_q;
        end
        rd_data <= mem[rd_addr];
    end

    // Distributor must not feed a frozen bank
    assert property (@(posedge clk) disable iff (reset)
        state == frame_capture_pkg::FROZEN |-> !wr.we);

endmodule

// File: frame_readout_apb.sv
`timescale 1ns/1ps
`include "frame_capture_settings.svh"

module frame_readout_apb (
    input  logic                              clk,
    input  logic                              reset,
    input  frame_capture_pkg::apb_req_t       apb_req,
    output frame_capture_pkg::apb_rsp_t       apb_rsp,
    input  logic                              frame_valid,
    input  logic                              overflow,
    input  logic                              armed,
    input  logic [`FC_PIXEL_ADDR_BITS-1:0]    pixel_count,
    output logic [`FC_BANK_ADDR_BITS-1:0]     rd_addr,
    input  logic [`FC_PIXEL_BITS-1:0]         bank_rd_data [`FC_NUM_BANKS],
    output logic                              rearm
);

    localparam int NB = `FC_NUM_BANKS;
    localparam int FRAME_PIXELS = `FC_FRAME_PIXELS;
    localparam int ABITS = `FC_BANK_ADDR_BITS;
    localparam int SBITS = (NB > 1) ? $clog2(NB) : 1;
    localparam logic [11:0] REG_CTRL = `FC_REG_CTRL;
    localparam logic [11:0] REG_STATUS = `FC_REG_STATUS;
    localparam logic [11:0] PIXEL_BASE = `FC_PIXEL_BASE;

    frame_capture_pkg::apb_phase_e phase_q;
    frame_capture_pkg::apb_phase_e phase;

    logic             setup;
    logic [11:0]      pix_offset;
    logic [9:0]       pix_index;
    logic             pixel_area;
    logic             pixel_in_frame;
    logic             pixel_read;
    logic             access_err;
    logic [31:0]      status_word;
    logic [31:0]      reg_rdata;
    logic [31:0]      prdata_q;
    logic             err_q;
    logic             rearm_q;
    logic [SBITS-1:0] sel_q;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign setup = apb_req.psel && !apb_req.penable;

    // Word-per-pixel layout above the base
    assign pix_offset = apb_req.paddr - PIXEL_BASE;
    assign pix_index = pix_offset[11:2];
    assign pixel_area = apb_req.paddr >= PIXEL_BASE;
    assign pixel_in_frame = int'(pix_index) < FRAME_PIXELS;
    assign pixel_read = pixel_area && pixel_in_frame && !apb_req.pwrite;

    always_comb begin
        if (pixel_area) begin
            access_err = apb_req.pwrite || !pixel_in_frame;
        end else if (apb_req.paddr == REG_STATUS) begin
            access_err = apb_req.pwrite;
        end else if (apb_req.paddr == REG_CTRL) begin
            access_err = 1'b0;
        end else begin
            access_err = 1'b1;
        end
    end

    assign status_word = {16'(pixel_count), 13'd0, armed, overflow, frame_valid};
    // CTRL reads back zero
    assign reg_rdata = (apb_req.paddr == REG_STATUS) ? status_word : 32'd0;

    // Same slot in every bank, the mux picks one later
    assign rd_addr = ABITS'(int'(pix_index) / NB);

    ////////////////////////////////////////
    // Phase tracking
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            phase_q <= frame_capture_pkg::IDLE;
        end else if (setup) begin
            // Pixel reads wait one cycle for the RAM register
            phase_q <= pixel_read ? frame_capture_pkg::ACCESS_WAIT
                                  : frame_capture_pkg::ACCESS_DONE;
        end else if (phase_q == frame_capture_pkg::ACCESS_WAIT) begin
            phase_q <= frame_capture_pkg::ACCESS_DONE;
        end else begin
            phase_q <= frame_capture_pkg::IDLE;
        end
    end

    assign phase = setup ? frame_capture_pkg::SETUP : phase_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            rearm_q <= 1'b0;
        end else if (setup) begin
            rearm_q <= apb_req.pwrite && apb_req.paddr == REG_CTRL && apb_req.pwdata[0];
        end
    end

    // Decode held through the access
    always_ff @(posedge clk) begin
        if (setup) begin
            err_q <= access_err;
            sel_q <= SBITS'(int'(pix_index) % NB);
            if (!pixel_read) begin
                prdata_q <= reg_rdata;
            end
        end else if (phase_q == frame_capture_pkg::ACCESS_WAIT) begin
            prdata_q <= 32'(bank_rd_data[sel_q]);
        end
    end

    ////////////////////////////////////////
    // Response
    ////////////////////////////////////////

    assign apb_rsp.pready = (phase == frame_capture_pkg::ACCESS_DONE);
    assign apb_rsp.pslverr = apb_rsp.pready && err_q;
    assign apb_rsp.prdata = prdata_q;

    // Pulse on the completing cycle, distributor clears on the next edge
    assign rearm = rearm_q && (phase_q == frame_capture_pkg::ACCESS_DONE);

    // Slave only completes while the master is in ACCESS
    assert property (@(posedge clk) disable iff (reset)
        apb_rsp.pready |-> apb_req.psel && apb_req.penable);

endmodule

// File: frame_capture_top.sv
`timescale 1ns/1ps
`include "frame_capture_settings.svh"

module frame_capture_top (
    input  logic                          clk,
    input  logic                          reset,
    input  frame_capture_pkg::cam_word_t  cam,
    input  frame_capture_pkg::apb_req_t   apb_req,
    output frame_capture_pkg::apb_rsp_t   apb_rsp
);

    frame_capture_pkg::bank_write_t       bank_wr [`FC_NUM_BANKS];
    logic [`FC_PIXEL_BITS-1:0]            bank_rd_data [`FC_NUM_BANKS];
    logic [`FC_BANK_ADDR_BITS-1:0]        rd_addr;
    logic [`FC_PIXEL_ADDR_BITS-1:0]       pixel_count;
    logic                                 frozen;
    logic                                 frame_valid;
    logic                                 overflow;
    logic                                 armed;
    logic                                 rearm;

    pixel_distributor u_distributor (
        .clk         (clk),
        .reset       (reset),
        .cam         (cam),
        .rearm       (rearm),
        .bank_wr     (bank_wr),
        .frozen      (frozen),
        .frame_valid (frame_valid),
        .overflow    (overflow),
        .armed       (armed),
        .pixel_count (pixel_count)
    );

    ////////////////////////////////////////
    // Frame banks
    ////////////////////////////////////////

    for (genvar i = 0; i < `FC_NUM_BANKS; i++) begin : g_bank
        frame_bank_writer u_writer (
            .clk     (clk),
            .reset   (reset),
            .wr      (bank_wr[i]),
            .frozen  (frozen),
            .rd_addr (rd_addr),
            .rd_data (bank_rd_data[i])
        );

        // Every bank settles frozen one cycle after the frame ends
        assert property (@(posedge clk) disable iff (reset)
            $rose(frozen) |=> u_writer.state == frame_capture_pkg::FROZEN);
    end

    frame_readout_apb u_readout (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .frame_valid  (frame_valid),
        .overflow     (overflow),
        .armed        (armed),
        .pixel_count  (pixel_count),
        .rd_addr      (rd_addr),
        .bank_rd_data (bank_rd_data),
        .rearm        (rearm)
    );

endmodule

// File: frame_capture_checker.sv
`timescale 1ns/1ps
`include "frame_capture_settings.svh"

module frame_capture_checker (
    input  logic                         clk,
    input  logic                         reset,
    input  frame_capture_pkg::cam_word_t cam,
    input  frame_capture_pkg::apb_req_t  apb_req,
    input  frame_capture_pkg::apb_rsp_t  apb_rsp,
    input  logic [127:0]                 test_name,
    input  logic [31:0]                  exp_status,
    input  logic                         test_end,
    output int                           error_count,
    output int                           tests_run,
    output int                           tests_failed
);

    localparam int FRAME_PIXELS = `FC_FRAME_PIXELS;
    localparam int PIXEL_BASE = `FC_PIXEL_BASE;
    localparam int REG_CTRL = `FC_REG_CTRL;
    localparam int REG_STATUS = `FC_REG_STATUS;

    // Reference frame, filled from the camera port alone
    logic [7:0] frame_model [FRAME_PIXELS];
    int         model_count;
    logic       model_frozen;
    // ACCESS cycles seen before pready
    int         wait_cycles;
    int         test_errors;
    logic       rearm_done;

    // Host re-arm lands on the completing edge
    assign rearm_done = apb_req.psel && apb_req.penable && apb_rsp.pready
                        && apb_req.pwrite && int'(apb_req.paddr) == REG_CTRL
                        && apb_req.pwdata[0];

    // Test name without the leading zero bytes
    function automatic string name_str(input logic [127:0] v);
        string      s;
        logic [7:0] c;
        s = "";
        for (int k = 15; k >= 0; k--) begin
            c = v[k*8 +: 8];
            if (c != 8'd0) begin
                s = $sformatf("%s%c", s, c);
            end
        end
        return s;
    endfunction

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s: %s expected %h actual %h", name_str(test_name), what, exp, act);
        error_count++;
        test_errors++;
    endtask

    ////////////////////////////////////////
    // APB completion checks
    ////////////////////////////////////////

    task automatic check_access();
        int   addr;
        int   idx;
        logic pixel;
        logic exp_err;
        int   exp_cycles;
        addr = int'(apb_req.paddr);
        idx = (addr - PIXEL_BASE) / 4;
        pixel = addr >= PIXEL_BASE;
        // Error rules of the register map
        if (pixel) begin
            exp_err = apb_req.pwrite || idx >= FRAME_PIXELS;
        end else if (addr == REG_STATUS) begin
            exp_err = apb_req.pwrite;
        end else begin
            exp_err = (addr != REG_CTRL);
        end
        // Only a good pixel read waits on the RAM
        exp_cycles = (pixel && !exp_err) ? 2 : 1;
        if (apb_rsp.pslverr != exp_err) begin
            mismatch("pslverr", 32'(exp_err), 32'(apb_rsp.pslverr));
        end
        if (wait_cycles + 1 != exp_cycles) begin
            mismatch("access cycles", 32'(exp_cycles), 32'(wait_cycles + 1));
        end
        if (!apb_req.pwrite && !exp_err) begin
            if (pixel) begin
                if (apb_rsp.prdata != {24'd0, frame_model[idx]}) begin
                    mismatch($sformatf("pixel %0d", idx), {24'd0, frame_model[idx]},
                             apb_rsp.prdata);
                end
            end else if (addr == REG_STATUS && apb_rsp.prdata != exp_status) begin
                mismatch("status", exp_status, apb_rsp.prdata);
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            model_frozen <= 1'b0;
            model_count <= 0;
            wait_cycles <= 0;
            error_count = 0;
            tests_run = 0;
            tests_failed = 0;
            test_errors = 0;
        end else begin
            if (apb_req.psel && apb_req.penable) begin
                if (apb_rsp.pready) begin
                    check_access();
                    wait_cycles <= 0;
                end else begin
                    wait_cycles <= wait_cycles + 1;
                end
            end
            // Frame model, frame_done beats a pixel in the same cycle
            if (rearm_done) begin
                model_frozen <= 1'b0;
                model_count <= 0;
            end else if (cam.frame_done) begin
                model_frozen <= 1'b1;
            end else if (cam.pixel_done && !model_frozen && model_count < FRAME_PIXELS) begin
                frame_model[model_count] <= cam.data[23:16];
                model_count <= model_count + 1;
            end
            // One line per finished test
            if (test_end) begin
                tests_run++;
                if (test_errors == 0) begin
                    $display("PASS %s", name_str(test_name));
                end else begin
                    tests_failed++;
                    $display("FAIL %s with %0d errors", name_str(test_name), test_errors);
                end
                test_errors = 0;
            end
        end
    end

endmodule

// File: frame_capture_tb.sv
`timescale 1ns/1ps
`include "frame_capture_settings.svh"

module frame_capture_tb;

    localparam logic [11:0] PIXEL_BASE = `FC_PIXEL_BASE;
    localparam logic [11:0] REG_CTRL = `FC_REG_CTRL;
    localparam logic [11:0] REG_STATUS = `FC_REG_STATUS;
    localparam int FRAME_PIXELS = `FC_FRAME_PIXELS;

    typedef enum logic [2:0] {
        OP_PIXELS,
        OP_FRAME_END,
        OP_READ,
        OP_WRITE,
        OP_READ_ALL
    } op_e;

    // One table row where arg is a count or an APB address
    typedef struct packed {
        logic [127:0] name;
        op_e          op;
        logic [11:0]  arg;
        logic [31:0]  wdata;
        logic [31:0]  exp;
    } step_t;

    logic                        clk;
    logic                        reset;
    frame_capture_pkg::cam_word_t cam;
    frame_capture_pkg::apb_req_t apb_req;
    frame_capture_pkg::apb_rsp_t apb_rsp;
    logic [127:0]                test_name;
    logic [31:0]                 exp_status;
    logic                        test_end;
    int                          error_count;
    int                          tests_run;
    int                          tests_failed;
    step_t                       steps [$];
    integer                      seed;
    int                          cycles = 0;
    int                          limit;

    frame_capture_top dut (
        .clk     (clk),
        .reset   (reset),
        .cam     (cam),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    frame_capture_checker u_check (
        .clk          (clk),
        .reset        (reset),
        .cam          (cam),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .test_name    (test_name),
        .exp_status   (exp_status),
        .test_end     (test_end),
        .error_count  (error_count),
        .tests_run    (tests_run),
        .tests_failed (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Camera and APB drivers
    ////////////////////////////////////////

    // Pulses at least one idle cycle apart
    task automatic send_pixels(input int n);
        int gap;
        for (int k = 0; k < n; k++) begin
            gap = 1 + int'($random(seed) & 1);
            @(posedge clk);
            cam <= {$random(seed), 1'b1, 1'b0};
            @(posedge clk);
            cam.pixel_done <= 1'b0;
            repeat (gap - 1) @(posedge clk);
        end
    endtask

    task automatic end_frame();
        @(posedge clk);
        cam.frame_done <= 1'b1;
        @(posedge clk);
        cam.frame_done <= 1'b0;
    endtask

    // SETUP then ACCESS until pready is seen mid-cycle
    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        apb_req <= {1'b1, 1'b0, wr, addr, data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) @(negedge clk);
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic read_frame(input int n);
        for (int k = 0; k < n; k++) begin
            apb_access(1'b0, PIXEL_BASE + 12'(4 * k), 32'd0);
        end
    endtask

    task automatic close_test();
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    task automatic run_step(input step_t s);
        @(posedge clk);
        test_name <= s.name;
        exp_status <= s.exp;
        case (s.op)
            OP_PIXELS:    send_pixels(int'(s.arg));
            OP_FRAME_END: end_frame();
            OP_READ:      apb_access(1'b0, s.arg, 32'd0);
            OP_WRITE:     apb_access(1'b1, s.arg, s.wdata);
            OP_READ_ALL:  read_frame(int'(s.arg));
            default:      ;
        endcase
    endtask

    function automatic void add_step(input logic [127:0] name, input op_e op,
                                     input logic [11:0] arg, input logic [31:0] wdata,
                                     input logic [31:0] exp);
        steps.push_back({name, op, arg, wdata, exp});
    endfunction

    function automatic int step_length(input step_t s);
        return (s.op == OP_PIXELS || s.op == OP_READ_ALL) ? int'(s.arg) : 1;
    endfunction

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    initial begin
        seed = 32'h4dcc_3174;
        reset = 1'b1;
        cam = '0;
        apb_req = '0;
        test_name = '0;
        exp_status = '0;
        test_end = 1'b0;
        // Status word is count, armed, overflow, valid
        add_step("full_frame", OP_PIXELS, 12'd64, 32'd0, 32'd0);
        add_step("full_frame", OP_FRAME_END, 12'd0, 32'd0, 32'd0);
        add_step("full_frame", OP_READ_ALL, 12'd64, 32'd0, 32'd0);
        add_step("full_frame", OP_READ, REG_STATUS, 32'd0, 32'h0040_0001);
        // Late pixels must not touch the frame
        add_step("frozen_frame", OP_PIXELS, 12'd10, 32'd0, 32'd0);
        add_step("frozen_frame", OP_READ_ALL, 12'd64, 32'd0, 32'd0);
        add_step("frozen_frame", OP_READ, REG_STATUS, 32'd0, 32'h0040_0001);
        // Short second frame over the old one
        add_step("rearm", OP_WRITE, REG_CTRL, 32'd1, 32'd0);
        add_step("rearm", OP_READ, REG_STATUS, 32'd0, 32'h0000_0004);
        add_step("rearm", OP_PIXELS, 12'd8, 32'd0, 32'd0);
        add_step("rearm", OP_FRAME_END, 12'd0, 32'd0, 32'd0);
        add_step("rearm", OP_READ, REG_STATUS, 32'd0, 32'h0008_0001);
        add_step("rearm", OP_READ_ALL, 12'd64, 32'd0, 32'd0);
        // Six pixels past the frame
        add_step("overflow", OP_WRITE, REG_CTRL, 32'd1, 32'd0);
        add_step("overflow", OP_PIXELS, 12'd70, 32'd0, 32'd0);
        add_step("overflow", OP_FRAME_END, 12'd0, 32'd0, 32'd0);
        add_step("overflow", OP_READ, REG_STATUS, 32'd0, 32'h0040_0003);
        add_step("overflow", OP_READ_ALL, 12'd64, 32'd0, 32'd0);
        // Out of frame, read-only, unmapped, then good accesses
        add_step("apb_errors", OP_READ, PIXEL_BASE + 12'(4 * FRAME_PIXELS), 32'd0, 32'd0);
        add_step("apb_errors", OP_WRITE, REG_STATUS, 32'd1, 32'd0);
        add_step("apb_errors", OP_WRITE, 12'h008, 32'd1, 32'd0);
        add_step("apb_errors", OP_READ, 12'h100, 32'd0, 32'd0);
        add_step("apb_errors", OP_WRITE, PIXEL_BASE, 32'h55, 32'd0);
        add_step("apb_errors", OP_READ, REG_STATUS, 32'd0, 32'h0040_0003);
        // Pixel 0 keeps its byte after the rejected write
        add_step("apb_errors", OP_READ, PIXEL_BASE, 32'd0, 32'd0);
        limit = 200;
        foreach (steps[k]) begin
            limit += 4 * step_length(steps[k]);
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i]);
            if (i == steps.size() - 1 || steps[i + 1].name != steps[i].name) begin
                close_test();
            end
        end
        repeat (2) @(posedge clk);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Run length bound from the table
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout, run stopped after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

// File: frame_capture.f
+incdir+.
frame_capture_pkg.sv
pixel_distributor.sv
frame_bank_writer.sv
frame_readout_apb.sv
frame_capture_top.sv
frame_capture_checker.sv
frame_capture_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the frame capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module frame_capture_tb \
    --Mdir obj_dir -o sim_frame_capture \
    -f frame_capture.f

./obj_dir/sim_frame_capture > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
